// ==== project.f ====
hdl/frame_pkg.sv
hdl/video_timing_if.sv
hdl/video_timing.sv
hdl/view_clear.sv
hdl/frame_port_arbiter.sv
hdl/frame_display_top.sv
verification/frame_display_properties.sv
verification/frame_display_tb.sv

// ==== Makefile ====
TOP = frame_display_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o sim_bin
	./obj_dir/sim_bin | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/frame_display_tb.sv ====
/*
 * Random-stimulus testbench for frame_display_top. Models the external
 * memory and predicts every memory command and display output.
 */
`timescale 1ns/1ps

module frame_display_tb;
   import frame_pkg::*;

   localparam int frame_cycles = h_total * v_total;
   localparam int max_reports  = 20;
   localparam int n_writes     = 150;

   logic      clk;
   logic      rst_n;
   offset_t   view_x;
   offset_t   view_y;
   angle_t    view_angle;
   logic      wr_strobe;
   mem_addr_t wr_addr;
   mem_word_t wr_data;
   mem_addr_t mem_addr;
   logic      mem_we;
   mem_word_t mem_wdata;
   mem_word_t mem_rdata;
   pixel_t    pixel;
   logic      hsync;
   logic      vsync;
   logic      blank;
   logic      clear_busy;

   // external memory and the reference copy
   mem_word_t mem [fb_words];
   mem_word_t ref_mem [fb_words];
   mem_word_t rd_pipe;

   // reference model state
   int        h;
   int        v;
   int        h_prev;
   int        v_prev;
   logic      pend;
   mem_addr_t pend_addr;
   mem_word_t pend_data;
   logic      exp_busy;
   int        clr_ptr;
   int        clear_writes;
   int        strobe_writes;
   offset_t   last_x;
   offset_t   last_y;
   angle_t    last_angle;
   logic      check_pixels;
   logic      count_on;
   int        nonblank_cnt;
   int        hsync_cnt;
   int        vsync_cnt;
   int        errors;
   int        test_start_errors;
   int        tests_run;
   int        tests_failed;
   string     test_name;

   frame_display_top uut (.*);

   bind frame_display_top frame_display_properties u_props (
      .clk        (clk),
      .rst_n      (rst_n),
      .hcount     (u_timing.h_cnt),
      .mem_we     (mem_we),
      .mem_wdata  (mem_wdata),
      .clear_busy (clear_busy),
      .view_x     (view_x),
      .view_y     (view_y),
      .view_angle (view_angle)
   );

   always #20 clk = ~clk;

   // two-cycle read latency, writes land at their own edge
   always @(posedge clk) begin
      if (mem_we && mem_addr < fb_words) mem[mem_addr] <= mem_wdata;
      rd_pipe   <= (mem_addr < fb_words) ? mem[mem_addr] : '0;
      mem_rdata <= rd_pipe;
   end

   task automatic report_value(string what, longint expected, longint actual);
      errors++;
      if (errors <= max_reports)
         $display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
   endtask

   task automatic report_event(string msg);
      errors++;
      $display("test %s: %s", test_name, msg);
   endtask

   ////////////////////////////////////////////////////////////
   // reference model, sampled at the rising edge
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      int        ph;
      int        g;
      logic      in_blank;
      logic      pb;
      logic      exp_we;
      mem_addr_t exp_addr;
      mem_word_t exp_data;
      mem_word_t word;
      pixel_t    exp_pix;
      if (rst_n) begin
         ph       = h % 4;
         g        = h / 4;
         in_blank = (h >= h_active) || (v >= v_active);
         exp_we   = 1'b0;
         exp_data = '0;
         // display prefetch, next group or word 0 of next line
         if (g == h_total / 4 - 1)
            exp_addr = mem_addr_t'(((v == v_total - 1) ? 0 : v + 1) * words_per_line);
         else
            exp_addr = mem_addr_t'(v * words_per_line + g + 1);
         assert (clear_busy == exp_busy) else report_value("clear_busy", exp_busy, clear_busy);
         if (exp_busy && (ph == 2 || (in_blank && ph % 2 == 1))) begin
            exp_we   = 1'b1;
            exp_addr = mem_addr_t'(clr_ptr);
            ref_mem[clr_ptr] = '0;
            if (clr_ptr == fb_words - 1) begin
               exp_busy = 1'b0;
               clr_ptr  = 0;
            end else begin
               clr_ptr++;
            end
         end else if (pend && !exp_busy && ph == 2) begin
            exp_we   = 1'b1;
            exp_addr = pend_addr;
            exp_data = pend_data;
            ref_mem[pend_addr] = pend_data;
            pend = 1'b0;
         end
         assert (mem_we == exp_we) else report_value("mem_we", exp_we, mem_we);
         assert (mem_addr == exp_addr) else report_value("mem_addr", exp_addr, mem_addr);
         if (exp_we) begin
            assert (mem_wdata == exp_data) else report_value("mem_wdata", exp_data, mem_wdata);
         end
         // writes the DUT actually issued, split by sweep state
         if (mem_we && clear_busy) begin
            clear_writes++;
         end else if (mem_we) begin
            strobe_writes++;
         end
         // any view change restarts the sweep next cycle
         if (view_x != last_x || view_y != last_y || view_angle != last_angle) begin
            exp_busy     = 1'b1;
            clr_ptr      = 0;
            clear_writes = 0;
         end
         last_x     = view_x;
         last_y     = view_y;
         last_angle = view_angle;
         if (wr_strobe) begin
            pend      = 1'b1;
            pend_addr = wr_addr;
            pend_data = {4'b0, wr_data[31:0]};
         end
         // registered outputs follow the previous beam position
         if (v_prev >= 0) begin
            pb = (h_prev >= h_active) || (v_prev >= v_active);
            assert (blank == pb) else report_value("blank", pb, blank);
            assert (hsync == (h_prev >= h_sync_start && h_prev < h_sync_end))
               else report_value("hsync", !hsync, hsync);
            assert (vsync == (v_prev >= v_sync_start && v_prev < v_sync_end))
               else report_value("vsync", !vsync, vsync);
            if (check_pixels) begin
               exp_pix = '0;
               if (!pb) begin
                  word    = ref_mem[v_prev * words_per_line + h_prev / 4];
                  exp_pix = word[8 * (h_prev % 4) +: 8];
               end
               assert (pixel == exp_pix) else report_value("pixel", exp_pix, pixel);
            end
            if (count_on) begin
               nonblank_cnt += !blank;
               hsync_cnt    += hsync;
               vsync_cnt    += vsync;
            end
         end
         h_prev = h;
         v_prev = v;
         if (h == h_total - 1) begin
            h = 0;
            v = (v == v_total - 1) ? 0 : v + 1;
         end else begin
            h++;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////////////////////////

   task automatic start_test(string name);
      test_name         = name;
      test_start_errors = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors != test_start_errors) tests_failed++;
      $display("test %s: done, %0d errors", test_name, errors - test_start_errors);
   endtask

   task automatic strobe_write(mem_addr_t addr, mem_word_t data);
      wr_strobe = 1'b1;
      wr_addr   = addr;
      wr_data   = data;
      @(negedge clk);
      wr_strobe = 1'b0;
   endtask

   // aligned to a frame start, past any readout of stale words
   task automatic check_frame();
      while (v != 1) @(negedge clk);
      while (!(h == 0 && v == 0)) @(negedge clk);
      check_pixels = 1'b1;
      repeat (frame_cycles) @(negedge clk);
      check_pixels = 1'b0;
   endtask

   task automatic wait_clear_done();
      int n;
      n = 0;
      @(negedge clk);
      while (clear_busy && n < frame_cycles) begin
         @(negedge clk);
         n++;
      end
      assert (!clear_busy) else report_event("clear still busy after one frame");
   endtask

   // watchdog, ten frames covers all five tests
   initial begin
      #(longint'(frame_cycles) * 10 * 40);
      $display("watchdog expired before the tests finished");
      $display("** FAIL **");
      $finish;
   end

   initial begin
      mem_addr_t a;
      mem_word_t d;
      mem_word_t d_kept;
      void'($urandom(32'hae96_91a9));
      clk = 1'b0;
      rst_n = 1'b0;
      view_x = 11'd100;
      view_y = 11'd200;
      view_angle = 9'd45;
      wr_strobe = 1'b0;
      wr_addr = '0;
      wr_data = '0;
      mem_rdata = '0;
      h = 0;
      v = 0;
      h_prev = 0;
      // no registered output to compare before the first cycle
      v_prev = -1;
      pend = 1'b0;
      exp_busy = 1'b0;
      check_pixels = 1'b0;
      count_on = 1'b0;
      pend_addr = '0;
      pend_data = '0;
      clr_ptr = 0;
      clear_writes = 0;
      strobe_writes = 0;
      nonblank_cnt = 0;
      hsync_cnt = 0;
      vsync_cnt = 0;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      last_x = view_x;
      last_y = view_y;
      last_angle = view_angle;
      for (int i = 0; i < fb_words; i++) begin
         mem[i]     = {4'b0, (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f};
         ref_mem[i] = mem[i];
      end
      repeat (16) @(negedge clk);
      start_test("reset_and_timing");
      assert (!mem_we && !clear_busy && !hsync && !vsync && pixel == '0)
         else report_event("outputs not low after reset");
      rst_n = 1'b1;
      count_on = 1'b1;
      repeat (frame_cycles) @(negedge clk);
      count_on = 1'b0;
      assert (nonblank_cnt == h_active * v_active)
         else report_value("active cycles", h_active * v_active, nonblank_cnt);
      assert (hsync_cnt == (h_sync_end - h_sync_start) * v_total)
         else report_value("hsync cycles", (h_sync_end - h_sync_start) * v_total, hsync_cnt);
      assert (vsync_cnt == (v_sync_end - v_sync_start) * h_total)
         else report_value("vsync cycles", (v_sync_end - v_sync_start) * h_total, vsync_cnt);
      end_test();

      start_test("random_writes");
      for (int i = 0; i < n_writes; i++) begin
         repeat ($urandom_range(20, 8)) @(negedge clk);
         // top nibble random too, it must never reach the memory
         strobe_write(mem_addr_t'($urandom_range(fb_words - 1, 0)),
                      {4'($urandom()), $urandom()});
      end
      repeat (8) @(negedge clk);
      assert (strobe_writes == n_writes) else report_value("writes", n_writes, strobe_writes);
      assert (clear_writes == 0) else report_value("clear writes", 0, clear_writes);
      end_test();

      start_test("readout_frame");
      check_frame();
      end_test();

      start_test("view_change_clear");
      view_x = view_x + offset_t'($urandom_range(100, 1));
      wait_clear_done();
      assert (clear_writes == fb_words) else report_value("clear writes", fb_words, clear_writes);
      check_frame();
      end_test();

      start_test("write_during_clear");
      strobe_writes = 0;
      view_angle = view_angle + angle_t'($urandom_range(50, 1));
      repeat (500) @(negedge clk);
      a = mem_addr_t'($urandom_range(fb_words - 1, 0));
      d = {4'($urandom()), $urandom()};
      // stored word keeps the low 32 bits, top nibble zero
      d_kept = {4'b0, d[31:0]};
      strobe_write(a, d);
      while (clear_writes < 50000) @(negedge clk);
      view_y = view_y + offset_t'($urandom_range(100, 1));
      wait_clear_done();
      repeat (8) @(negedge clk);
      assert (clear_writes == fb_words) else report_value("clear writes", fb_words, clear_writes);
      assert (strobe_writes == 1) else report_value("held writes", 1, strobe_writes);
      assert (mem[a] == d_kept) else report_value("held word", d_kept, mem[a]);
      end_test();

      $display("tests run %0d, tests failed %0d, checks failed %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== verification/frame_display_properties.sv ====
/*
 * Concurrent checks on the frame memory port and the clear sweep.
 * Bound into frame_display_top by the testbench.
 */
`timescale 1ns/1ps

module frame_display_properties (
   input logic                 clk,
   input logic                 rst_n,
   input frame_pkg::hcount_t   hcount,
   input logic                 mem_we,
   input frame_pkg::mem_word_t mem_wdata,
   input logic                 clear_busy,
   input frame_pkg::offset_t   view_x,
   input frame_pkg::offset_t   view_y,
   input frame_pkg::angle_t    view_angle
);
   import frame_pkg::*;

   localparam int frame_cycles = h_total * v_total;

   offset_t prev_x;
   offset_t prev_y;
   angle_t  prev_angle;
   int      busy_len;

   always_ff @(posedge clk) begin
      prev_x     <= view_x;
      prev_y     <= view_y;
      prev_angle <= view_angle;
   end

   // cycles since the last change while a sweep runs
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_len <= 0;
      end else if (!clear_busy || view_x != prev_x || view_y != prev_y
                   || view_angle != prev_angle) begin
         busy_len <= 0;
      end else begin
         busy_len <= busy_len + 1;
      end
   end

   // phase 0 always belongs to display readout
   a_no_write_phase0: assert property (@(posedge clk) disable iff (!rst_n)
      !(mem_we && hcount[1:0] == 2'd0))
      else $error("memory write issued in phase 0");

   a_clear_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (clear_busy && mem_we) |-> (mem_wdata == '0))
      else $error("nonzero write data during clear");

   a_clear_bounded: assert property (@(posedge clk) disable iff (!rst_n)
      busy_len < frame_cycles)
      else $error("clear sweep longer than one frame");

endmodule

// ==== hdl/frame_display_top.sv ====
/*
 * Frame-buffer display top level. Connects beam timing, the view-change
 * clear engine and the memory port arbiter to plain ports.
 */
`timescale 1ns/1ps

module frame_display_top (
   input  logic                 clk,
   input  logic                 rst_n,
   // view, any change clears the frame
   input  frame_pkg::offset_t   view_x,
   input  frame_pkg::offset_t   view_y,
   input  frame_pkg::angle_t    view_angle,
   // pixel writer
   input  logic                 wr_strobe,
   input  frame_pkg::mem_addr_t wr_addr,
   input  frame_pkg::mem_word_t wr_data,
   // external synchronous frame memory
   output frame_pkg::mem_addr_t mem_addr,
   output logic                 mem_we,
   output frame_pkg::mem_word_t mem_wdata,
   input  frame_pkg::mem_word_t mem_rdata,
   // display
   output frame_pkg::pixel_t    pixel,
   output logic                 hsync,
   output logic                 vsync,
   output logic                 blank,
   output logic                 clear_busy
);
   import frame_pkg::*;

   logic      clear_active;
   logic      clear_grant;
   mem_addr_t clear_addr;

   video_timing_if vt_if ();

   video_timing u_timing (
      .clk   (clk),
      .rst_n (rst_n),
      .vt    (vt_if.source)
   );

   view_clear u_clear (
      .clk          (clk),
      .rst_n        (rst_n),
      .view_x       (view_x),
      .view_y       (view_y),
      .view_angle   (view_angle),
      .clear_grant  (clear_grant),
      .clear_active (clear_active),
      .clear_addr   (clear_addr)
   );

   frame_port_arbiter u_arbiter (
      .clk          (clk),
      .rst_n        (rst_n),
      .vt           (vt_if.sink),
      .clear_active (clear_active),
      .clear_addr   (clear_addr),
      .clear_grant  (clear_grant),
      .wr_strobe    (wr_strobe),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .mem_addr     (mem_addr),
      .mem_we       (mem_we),
      .mem_wdata    (mem_wdata),
      .mem_rdata    (mem_rdata),
      .pixel        (pixel),
      .hsync        (hsync),
      .vsync        (vsync),
      .blank        (blank)
   );

   assign clear_busy = clear_active;

endmodule

// ==== hdl/frame_port_arbiter.sv ====
/*
 * Shares the single frame memory port by pixel phase between display
 * readout, the clear sweep and the pixel writer, then unpacks pixels.
 */
`timescale 1ns/1ps

module frame_port_arbiter (
   input  logic                 clk,
   input  logic                 rst_n,
   video_timing_if.sink         vt,
   input  logic                 clear_active,
   input  frame_pkg::mem_addr_t clear_addr,
   output logic                 clear_grant,
   input  logic                 wr_strobe,
   input  frame_pkg::mem_addr_t wr_addr,
   input  frame_pkg::mem_word_t wr_data,
   output frame_pkg::mem_addr_t mem_addr,
   output logic                 mem_we,
   output frame_pkg::mem_word_t mem_wdata,
   input  frame_pkg::mem_word_t mem_rdata,
   output frame_pkg::pixel_t    pixel,
   output logic                 hsync,
   output logic                 vsync,
   output logic                 blank
);
   import frame_pkg::*;

   logic [phase_bits-1:0] phase;
   logic [group_bits-1:0] group;
   logic [group_bits-1:0] pf_col;
   vcount_t               pf_line;
   mem_addr_t             pf_addr;
   logic                  wr_pending;
   mem_addr_t             hold_addr;
   mem_word_t             hold_data;
   logic                  wr_grant;
   logic [1:0]            rd_tag;
   mem_word_t             fetch_word;
   mem_word_t             disp_word;

   assign phase = vt.hcount[phase_bits-1:0];
   assign group = vt.hcount[$bits(hcount_t)-1:phase_bits];

   ////////////////////////////////////////////////////////////
   // prefetch address, one group ahead of the beam
   ////////////////////////////////////////////////////////////

   always_comb begin
      if (group == group_bits'(groups_per_line - 1)) begin
         // last group wraps to word 0 of the next line
         pf_col  = '0;
         pf_line = (vt.vcount == vcount_t'(v_total - 1)) ? '0 : vt.vcount + 1'b1;
      end else begin
         pf_col  = group + 1'b1;
         pf_line = vt.vcount;
      end
   end

   assign pf_addr = mem_addr_t'(pf_line) * mem_addr_t'(words_per_line) + mem_addr_t'(pf_col);

   ////////////////////////////////////////////////////////////
   // write holding register
   ////////////////////////////////////////////////////////////

   // a later strobe simply replaces an unwritten word
   always_ff @(posedge clk) begin
      if (wr_strobe) begin
         hold_addr <= wr_addr;
         hold_data <= {4'b0, wr_data[31:0]};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_pending <= 1'b0;
      end else if (wr_strobe) begin
         wr_pending <= 1'b1;
      end else if (wr_grant) begin
         wr_pending <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // slot schedule
   ////////////////////////////////////////////////////////////

   // clear owns phase 2, plus phases 1 and 3 during blank
   assign clear_grant = clear_active && ((phase == phase_bits'(2)) || (vt.blank && phase[0]));
   // held write waits for a phase 2 with no clear running
   assign wr_grant = !clear_active && wr_pending && (phase == phase_bits'(2));

   always_comb begin
      mem_we   = clear_grant || wr_grant;
      mem_addr = pf_addr;
      if (clear_grant) begin
         mem_addr = clear_addr;
      end else if (wr_grant) begin
         mem_addr = hold_addr;
      end
   end

   // zero data for the whole sweep
   assign mem_wdata = clear_active ? '0 : hold_data;

   ////////////////////////////////////////////////////////////
   // readout and display outputs
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_tag     <= '0;
         fetch_word <= '0;
         disp_word  <= '0;
         pixel      <= '0;
         hsync      <= 1'b0;
         vsync      <= 1'b0;
         blank      <= 1'b1;
      end else begin
         // phase 0 read returns two cycles later
         rd_tag <= {rd_tag[0], (phase == '0)};
         if (rd_tag[1]) begin
            fetch_word <= mem_rdata;
         end
         // hand over at the group boundary
         if (phase == phase_bits'(pixels_per_word - 1)) begin
            disp_word <= fetch_word;
         end
         pixel <= vt.blank ? '0 : disp_word[8*phase +: 8];
         hsync <= vt.hsync;
         vsync <= vt.vsync;
         blank <= vt.blank;
      end
   end

endmodule

// ==== hdl/view_clear.sv ====
/*
 * Clears the whole frame buffer when the view position or angle changes.
 * Sweeps word addresses in order, one per grant from the port arbiter.
 */
`timescale 1ns/1ps

module view_clear (
   input  logic                 clk,
   input  logic                 rst_n,
   input  frame_pkg::offset_t   view_x,
   input  frame_pkg::offset_t   view_y,
   input  frame_pkg::angle_t    view_angle,
   input  logic                 clear_grant,
   output logic                 clear_active,
   output frame_pkg::mem_addr_t clear_addr
);
   import frame_pkg::*;

   offset_t prev_x;
   offset_t prev_y;
   angle_t  prev_angle;
   logic    view_changed;
   logic    last_word;

   ////////////////////////////////////////////////////////////
   // change detect
   ////////////////////////////////////////////////////////////

   // previous view, follows the inputs through reset as well
   // so a view set during reset does not start a sweep
   always_ff @(posedge clk) begin
      prev_x     <= view_x;
      prev_y     <= view_y;
      prev_angle <= view_angle;
   end

   assign view_changed = (view_x != prev_x) || (view_y != prev_y) || (view_angle != prev_angle);

   ////////////////////////////////////////////////////////////
   // address sweep
   ////////////////////////////////////////////////////////////

   assign last_word = (clear_addr == mem_addr_t'(fb_words - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         clear_active <= 1'b0;
         clear_addr   <= '0;
      end else if (view_changed) begin
         // a new change always restarts from word 0
         clear_active <= 1'b1;
         clear_addr   <= '0;
      end else if (clear_active && clear_grant) begin
         if (last_word) begin
            clear_active <= 1'b0;
            clear_addr   <= '0;
         end else begin
            clear_addr <= clear_addr + 1'b1;
         end
      end
   end

endmodule

// ==== hdl/video_timing.sv ====
/*
 * Free-running 800x600 beam counters with sync and blank decode.
 * Drives the source side of video_timing_if.
 */
`timescale 1ns/1ps

module video_timing (
   input  logic           clk,
   input  logic           rst_n,
   video_timing_if.source vt
);
   import frame_pkg::*;

   hcount_t h_cnt;
   vcount_t v_cnt;
   logic    h_last;
   logic    v_last;

   ////////////////////////////////////////////////////////////
   // counters
   ////////////////////////////////////////////////////////////

   // end of line and end of frame
   assign h_last = (h_cnt == hcount_t'(h_total - 1));
   assign v_last = (v_cnt == vcount_t'(v_total - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         if (h_last) begin
            h_cnt <= '0;
            // line advances only at the end of a line
            if (v_last) begin
               v_cnt <= '0;
            end else begin
               v_cnt <= v_cnt + 1'b1;
            end
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // sync and blank decode
   ////////////////////////////////////////////////////////////

   assign vt.hcount = h_cnt;
   assign vt.vcount = v_cnt;

   // positive sync pulses
   assign vt.hsync = (h_cnt >= hcount_t'(h_sync_start)) && (h_cnt < hcount_t'(h_sync_end));
   assign vt.vsync = (v_cnt >= vcount_t'(v_sync_start)) && (v_cnt < vcount_t'(v_sync_end));

   // blank anywhere outside the visible area
   assign vt.blank = (h_cnt >= hcount_t'(h_active)) || (v_cnt >= vcount_t'(v_active));

endmodule

// ==== hdl/video_timing_if.sv ====
/*
 * Beam position, sync and blank from the timing generator to the
 * memory port arbiter.
 */
`timescale 1ns/1ps

interface video_timing_if;
   import frame_pkg::*;

   hcount_t hcount;
   vcount_t vcount;
   logic    hsync;
   logic    vsync;
   logic    blank;

   // timing generator side
   modport source (output hcount, vcount, hsync, vsync, blank);
   // consumer side
   modport sink (input hcount, vcount, hsync, vsync, blank);

endinterface

// ==== hdl/frame_pkg.sv ====
/*
 * Timing, frame-buffer geometry and shared types for the display.
 * Modules import this in their bodies and use scoped names in port lists.
 */
package frame_pkg;

   ////////////////////////////////////////////////////////////
   // 800x600 video timing
   ////////////////////////////////////////////////////////////

   // horizontal, in pixel clocks
   localparam int h_active     = 800;
   localparam int h_sync_start = 840;
   localparam int h_sync_end   = 968;
   localparam int h_total      = 1056;

   // vertical, in lines
   localparam int v_active     = 600;
   localparam int v_sync_start = 601;
   localparam int v_sync_end   = 605;
   localparam int v_total      = 628;

   ////////////////////////////////////////////////////////////
   // frame-buffer geometry
   ////////////////////////////////////////////////////////////

   // four grey pixels per 36-bit word, pixel 0 in the low byte
   localparam int pixels_per_word = 4;
   localparam int words_per_line  = h_active / pixels_per_word;
   localparam int fb_words        = words_per_line * v_active;

   // hcount splits into a word phase and a group number
   localparam int phase_bits      = $clog2(pixels_per_word);
   localparam int groups_per_line = h_total / pixels_per_word;

   ////////////////////////////////////////////////////////////
   // types
   ////////////////////////////////////////////////////////////

   typedef logic [10:0] hcount_t;
   typedef logic [9:0]  vcount_t;
   typedef logic [18:0] mem_addr_t;
   // top 4 bits unused, always written as zero
   typedef logic [35:0] mem_word_t;
   typedef logic [7:0]  pixel_t;
   typedef logic [10:0] offset_t;
   typedef logic [8:0]  angle_t;

   localparam int group_bits = $bits(hcount_t) - phase_bits;

endpackage
